// File: Bender.yml
package:
  name: soc_top

sources:
  - soc_pkg.sv
  - reset_sequencer.sv
  - wb_decoder.sv
  - boot_rom.sv
  - scratch_ram.sv
  - csr_bridge.sv
  - sysctl.sv
  - soc_top.sv
  - target: test
    files:
      - tb_soc_assert.sv
      - tb_soc.sv

// File: boot_rom.hex
// boot rom image, one 32-bit hex word per line, word 0 first
98000000
D0000000
78010000
38210000
78020000
38420000
58200000
58400004
34210004
5C22FFFE
78030000
38630000
C0600000
00000000
13004D31
DEADBEEF

// File: boot_rom.sv
// boot rom: read-only word store in the flash slot, one cycle ack
`timescale 1ns/100ps

module boot_rom #(
	parameter int ROM_ADDR_WIDTH = 4
) (
	input  logic             sys_clk_i,
	input  logic             sys_rst_i,
	input  soc_pkg::wb_req_t wb_req_i,
	output soc_pkg::wb_rsp_t wb_rsp_o
);

	soc_pkg::wb_data_t         rom [2**ROM_ADDR_WIDTH];
	soc_pkg::wb_data_t         dat_q;
	logic [ROM_ADDR_WIDTH-1:0] idx;
	logic                      ack_q;

	initial $readmemh("boot_rom.hex", rom);

	// word index, aliases across the whole slot
	assign idx = wb_req_i.adr[ROM_ADDR_WIDTH+1:2];

	always_ff @(posedge sys_clk_i) begin
		dat_q <= rom[idx];
	end

	// writes get acked too, contents untouched
	always_ff @(posedge sys_clk_i) begin
		if (sys_rst_i)
			ack_q <= 1'b0;
		else
			ack_q <= wb_req_i.cyc & wb_req_i.stb & ~ack_q;
	end

	assign wb_rsp_o.dat_r = dat_q;
	assign wb_rsp_o.ack   = ack_q;
	assign wb_rsp_o.err   = 1'b0;

endmodule

// File: csr_bridge.sv
// csr bridge: turns one bus cycle into a single csr access, acks on the third cycle
`timescale 1ns/100ps

module csr_bridge (
	input  logic              sys_clk_i,
	input  logic              sys_rst_i,
	input  soc_pkg::wb_req_t  wb_req_i,
	input  soc_pkg::wb_data_t csr_dr_i,
	output soc_pkg::wb_rsp_t  wb_rsp_o,
	output soc_pkg::csr_req_t csr_req_o
);

	typedef enum logic [1:0] {IDLE, ACCESS, REPLY} state_t;

	state_t             state_q;
	logic               start;
	logic               ack_q;
	logic               csr_we_q;
	soc_pkg::csr_adr_t  csr_adr_q;
	soc_pkg::wb_data_t  csr_dw_q;
	soc_pkg::wb_data_t  dat_q;

	// new cycle only from idle and not in the ack cycle
	assign start = wb_req_i.cyc & wb_req_i.stb & ~ack_q & (state_q == IDLE);

	// --------------------
	// fsm
	// --------------------
	// idle -> access (we pulse) -> reply (capture) -> ack
	always_ff @(posedge sys_clk_i) begin
		if (sys_rst_i) begin
			state_q  <= IDLE;
			ack_q    <= 1'b0;
			csr_we_q <= 1'b0;
		end else begin
			ack_q    <= 1'b0;
			csr_we_q <= 1'b0;
			case (state_q)
				IDLE: begin
					if (start) begin
						state_q  <= ACCESS;
						csr_we_q <= wb_req_i.we;
					end
				end
				ACCESS: state_q <= REPLY;
				REPLY: begin
					state_q <= IDLE;
					ack_q   <= 1'b1;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// word address bits 15..2 map onto csr address
	always_ff @(posedge sys_clk_i) begin
		if (start) begin
			csr_adr_q <= wb_req_i.adr[15:2];
			csr_dw_q  <= wb_req_i.dat_w;
		end
		// peripheral read data valid now
		if (state_q == REPLY)
			dat_q <= csr_dr_i;
	end

	always_comb begin
		csr_req_o.adr  = csr_adr_q;
		csr_req_o.we   = csr_we_q;
		csr_req_o.dw   = csr_dw_q;
		wb_rsp_o.dat_r = dat_q;
		wb_rsp_o.ack   = ack_q;
		wb_rsp_o.err   = 1'b0;
	end

endmodule

// File: reset_sequencer.sv
// reset sequencer: stretches system reset and releases flash reset first
`timescale 1ns/100ps

module reset_sequencer #(
	parameter int RST_HOLD_CYCLES  = 1048575,
	parameter int FLASH_RST_CYCLES = 128
) (
	input  logic sys_clk_i,
	input  logic trigger_reset_i,
	input  logic reset_req_i,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	localparam int HOLD_W  = $clog2(RST_HOLD_CYCLES + 1);
	localparam int FLASH_W = $clog2(FLASH_RST_CYCLES + 1);
	localparam logic [HOLD_W-1:0]  HOLD_LOAD  = HOLD_W'(RST_HOLD_CYCLES);
	localparam logic [FLASH_W-1:0] FLASH_LAST = FLASH_W'(FLASH_RST_CYCLES - 1);

	logic               rst_src;
	logic [HOLD_W-1:0]  hold_cnt_q;
	logic [HOLD_W-1:0]  hold_nxt;
	logic               sys_rst_q;
	logic [FLASH_W-1:0] flash_cnt_q;
	logic [FLASH_W-1:0] flash_nxt;
	logic               flash_rst_n_q;

	// external trigger or software/button request
	assign rst_src = trigger_reset_i | reset_req_i;

	// --------------------
	// debounce / hold counter
	// --------------------
	// reload on any source, then count down to zero
	always_comb begin
		if (rst_src)
			hold_nxt = HOLD_LOAD;
		else if (hold_cnt_q != '0)
			hold_nxt = hold_cnt_q - 1'b1;
		else
			hold_nxt = hold_cnt_q;
	end

	// --------------------
	// flash release counter
	// --------------------
	// cleared by the same sources, saturates at the last cycle
	always_comb begin
		if (rst_src)
			flash_nxt = '0;
		else if (flash_cnt_q != FLASH_LAST)
			flash_nxt = flash_cnt_q + 1'b1;
		else
			flash_nxt = flash_cnt_q;
	end

	// flags registered from the next count so release lands on the exact cycle
	always_ff @(posedge sys_clk_i) begin
		hold_cnt_q    <= hold_nxt;
		sys_rst_q     <= (hold_nxt != '0);
		flash_cnt_q   <= flash_nxt;
		flash_rst_n_q <= (flash_nxt == FLASH_LAST);
	end

	assign sys_rst_o     = sys_rst_q;
	assign flash_rst_n_o = flash_rst_n_q;

endmodule

// File: scratch_ram.sv
// scratch ram: byte-writable word store in the sdram slot, one cycle ack
`timescale 1ns/100ps

module scratch_ram #(
	parameter int RAM_ADDR_WIDTH = 10
) (
	input  logic             sys_clk_i,
	input  logic             sys_rst_i,
	input  soc_pkg::wb_req_t wb_req_i,
	output soc_pkg::wb_rsp_t wb_rsp_o
);

	soc_pkg::wb_data_t         mem [2**RAM_ADDR_WIDTH];
	soc_pkg::wb_data_t         dat_q;
	logic [RAM_ADDR_WIDTH-1:0] idx;
	logic                      req;
	logic                      ack_q;

	// word index, aliases modulo depth
	assign idx = wb_req_i.adr[RAM_ADDR_WIDTH+1:2];

	// only the first cycle of a request counts
	assign req = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

	// --------------------
	// storage
	// --------------------
	always_ff @(posedge sys_clk_i) begin
		if (req && wb_req_i.we) begin
			// byte lanes
			for (int lane = 0; lane < 4; lane++) begin
				if (wb_req_i.sel[lane])
					mem[idx][lane*8 +: 8] <= wb_req_i.dat_w[lane*8 +: 8];
			end
		end
		// read old word, ready with ack
		dat_q <= mem[idx];
	end

	// --------------------
	// handshake
	// --------------------
	always_ff @(posedge sys_clk_i) begin
		if (sys_rst_i)
			ack_q <= 1'b0;
		else
			ack_q <= req;
	end

	assign wb_rsp_o.dat_r = dat_q;
	assign wb_rsp_o.ack   = ack_q;
	assign wb_rsp_o.err   = 1'b0;

endmodule

// File: soc_pkg.sv
// soc shared definitions: bus types, address map and system controller registers
package soc_pkg;

	// --------------------
	// bus widths
	// --------------------
	typedef logic [31:0] wb_adr_t;
	typedef logic [31:0] wb_data_t;
	typedef logic [3:0]  wb_sel_t;

	// master side of the bus
	typedef struct packed {
		wb_adr_t  adr;
		wb_data_t dat_w;
		wb_sel_t  sel;
		logic     we;
		logic     cyc;
		logic     stb;
	} wb_req_t;

	// slave side, err only ever with ack
	typedef struct packed {
		wb_data_t dat_r;
		logic     ack;
		logic     err;
	} wb_rsp_t;

	// --------------------
	// csr bus
	// --------------------
	// upper 4 bits peripheral, lower 10 bits register word
	typedef logic [13:0] csr_adr_t;

	typedef struct packed {
		csr_adr_t adr;
		logic     we;
		wb_data_t dw;
	} csr_req_t;

	// --------------------
	// address map
	// --------------------
	typedef enum logic [1:0] {SLOT_ROM, SLOT_RAM, SLOT_CSR, SLOT_NONE} slot_t;

	// patterns on adr[30:28] resp. adr[30:29]
	localparam logic [2:0] SLOT_ROM_SEL = 3'b000;
	localparam logic [1:0] SLOT_RAM_SEL = 2'b10;
	localparam logic [1:0] SLOT_CSR_SEL = 2'b11;

	// adr[31:LOCKED_MSB] all zero means null-pointer region
	localparam int LOCKED_MSB = 18;

	// --------------------
	// system controller
	// --------------------
	localparam logic [3:0] CSR_SYSCTL = 4'd1;

	localparam logic [9:0] SYSCTL_GPIO_IN    = 10'd0;
	localparam logic [9:0] SYSCTL_GPIO_OUT   = 10'd1;
	localparam logic [9:0] SYSCTL_CONTROL    = 10'd2;
	localparam logic [9:0] SYSCTL_SYSTEM_ID  = 10'd3;
	localparam logic [9:0] SYSCTL_HARD_RESET = 10'd4;

	localparam logic [31:0] SYSTEM_ID = 32'h13004D31;

	typedef logic [7:0] led_t;
	// left, select, right
	typedef logic [2:0] btn_t;

endpackage

// File: soc_top.sv
// soc top level: reset sequencer, bus decoder, boot rom, scratch ram and csr path
`timescale 1ns/100ps

module soc_top #(
	parameter int RST_HOLD_CYCLES  = 1048575,
	parameter int FLASH_RST_CYCLES = 128,
	parameter int ROM_ADDR_WIDTH   = 4,
	parameter int RAM_ADDR_WIDTH   = 10
) (
	input  logic             sys_clk_i,
	input  logic             trigger_reset_i,
	input  soc_pkg::wb_req_t wb_req_i,
	output soc_pkg::wb_rsp_t wb_rsp_o,
	input  soc_pkg::btn_t    btn_i,
	output soc_pkg::led_t    led_o,
	output logic             flash_rst_n_o,
	output logic             periph_rst_n_o
);

	logic              sys_rst;
	logic              reset_req;
	logic              bus_errors_en;
	soc_pkg::wb_req_t  rom_req;
	soc_pkg::wb_rsp_t  rom_rsp;
	soc_pkg::wb_req_t  ram_req;
	soc_pkg::wb_rsp_t  ram_rsp;
	soc_pkg::wb_req_t  brg_req;
	soc_pkg::wb_rsp_t  brg_rsp;
	soc_pkg::csr_req_t csr_req;
	soc_pkg::wb_data_t csr_dr;

	// --------------------
	// reset
	// --------------------
	reset_sequencer #(
		.RST_HOLD_CYCLES (RST_HOLD_CYCLES),
		.FLASH_RST_CYCLES(FLASH_RST_CYCLES)
	) u_reset_sequencer (
		.sys_clk_i      (sys_clk_i),
		.trigger_reset_i(trigger_reset_i),
		.reset_req_i    (reset_req),
		.sys_rst_o      (sys_rst),
		.flash_rst_n_o  (flash_rst_n_o)
	);

	assign periph_rst_n_o = ~sys_rst;

	// --------------------
	// bus
	// --------------------
	wb_decoder u_wb_decoder (
		.sys_clk_i      (sys_clk_i),
		.sys_rst_i      (sys_rst),
		.wb_req_i       (wb_req_i),
		.bus_errors_en_i(bus_errors_en),
		.wb_rsp_o       (wb_rsp_o),
		.rom_req_o      (rom_req),
		.rom_rsp_i      (rom_rsp),
		.ram_req_o      (ram_req),
		.ram_rsp_i      (ram_rsp),
		.csr_req_o      (brg_req),
		.csr_rsp_i      (brg_rsp)
	);

	// flash slot
	boot_rom #(.ROM_ADDR_WIDTH(ROM_ADDR_WIDTH)) u_boot_rom (
		.sys_clk_i(sys_clk_i),
		.sys_rst_i(sys_rst),
		.wb_req_i (rom_req),
		.wb_rsp_o (rom_rsp)
	);

	// sdram slot
	scratch_ram #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) u_scratch_ram (
		.sys_clk_i(sys_clk_i),
		.sys_rst_i(sys_rst),
		.wb_req_i (ram_req),
		.wb_rsp_o (ram_rsp)
	);

	// --------------------
	// csr path
	// --------------------
	csr_bridge u_csr_bridge (
		.sys_clk_i(sys_clk_i),
		.sys_rst_i(sys_rst),
		.wb_req_i (brg_req),
		.csr_dr_i (csr_dr),
		.wb_rsp_o (brg_rsp),
		.csr_req_o(csr_req)
	);

	// only csr peripheral, no read-data combine
	sysctl u_sysctl (
		.sys_clk_i      (sys_clk_i),
		.sys_rst_i      (sys_rst),
		.csr_req_i      (csr_req),
		.btn_i          (btn_i),
		.csr_dr_o       (csr_dr),
		.led_o          (led_o),
		.bus_errors_en_o(bus_errors_en),
		.reset_req_o    (reset_req)
	);

endmodule

// File: sources.f
soc_pkg.sv
reset_sequencer.sv
wb_decoder.sv
boot_rom.sv
scratch_ram.sv
csr_bridge.sv
sysctl.sv
soc_top.sv
tb_soc_assert.sv
tb_soc.sv

// File: sysctl.sv
// system controller: gpio, bus-error enable, system id and hard reset request
`timescale 1ns/100ps

module sysctl (
	input  logic              sys_clk_i,
	input  logic              sys_rst_i,
	input  soc_pkg::csr_req_t csr_req_i,
	input  soc_pkg::btn_t     btn_i,
	output soc_pkg::wb_data_t csr_dr_o,
	output soc_pkg::led_t     led_o,
	output logic              bus_errors_en_o,
	output logic              reset_req_o
);

	soc_pkg::btn_t     btn_meta_q;
	soc_pkg::btn_t     btn_sync_q;
	soc_pkg::led_t     led_q;
	logic              errors_en_q;
	soc_pkg::wb_data_t dr_q;
	logic              sel;
	logic              wr;
	logic [9:0]        reg_idx;

	// decode
	assign sel     = (csr_req_i.adr[13:10] == soc_pkg::CSR_SYSCTL);
	assign reg_idx = csr_req_i.adr[9:0];
	assign wr      = csr_req_i.we & sel;

	// --------------------
	// button synchronizer
	// --------------------
	always_ff @(posedge sys_clk_i) begin
		btn_meta_q <= btn_i;
		btn_sync_q <= btn_meta_q;
	end

	// --------------------
	// registers
	// --------------------
	always_ff @(posedge sys_clk_i) begin
		if (sys_rst_i) begin
			led_q       <= '0;
			errors_en_q <= 1'b0;
		end else if (wr) begin
			if (reg_idx == soc_pkg::SYSCTL_GPIO_OUT)
				led_q <= csr_req_i.dw[7:0];
			// control bit 0, rest reserved
			if (reg_idx == soc_pkg::SYSCTL_CONTROL)
				errors_en_q <= csr_req_i.dw[0];
		end
	end

	// read data one cycle after the access, zero when not addressed
	always_ff @(posedge sys_clk_i) begin
		dr_q <= '0;
		if (sel) begin
			case (reg_idx)
				soc_pkg::SYSCTL_GPIO_IN:   dr_q <= {29'd0, btn_sync_q};
				soc_pkg::SYSCTL_GPIO_OUT:  dr_q <= {24'd0, led_q};
				soc_pkg::SYSCTL_CONTROL:   dr_q <= {31'd0, errors_en_q};
				soc_pkg::SYSCTL_SYSTEM_ID: dr_q <= soc_pkg::SYSTEM_ID;
				default:                   dr_q <= '0;
			endcase
		end
	end

	// hard reset on any write, or all three buttons held
	// kept combinational so sys_rst lands before the bridge ack
	assign reset_req_o = (wr & (reg_idx == soc_pkg::SYSCTL_HARD_RESET)) | (&btn_sync_q);

	assign csr_dr_o        = dr_q;
	assign led_o           = led_q;
	assign bus_errors_en_o = errors_en_q;

endmodule

// File: tb_soc.sv
// testbench for the soc top level: reset timing, random bus traffic against models, csr checks
`timescale 1ns/100ps

module tb_soc;

	localparam int RST_HOLD_CYCLES  = 40;
	localparam int FLASH_RST_CYCLES = 12;
	localparam int ROM_ADDR_WIDTH   = 4;
	localparam int RAM_ADDR_WIDTH   = 6;
	localparam int RAM_WORDS        = 2**RAM_ADDR_WIDTH;
	localparam int ROM_WORDS        = 2**ROM_ADDR_WIDTH;
	localparam int RAM_OPS          = 200;
	// about 450 accesses of up to 5 cycles plus four reset waits of ~50, wide margin
	localparam int TIMEOUT_CYCLES   = 20000;

	// expected boot image
	localparam soc_pkg::wb_data_t ROM_IMAGE [16] = '{
		32'h98000000, 32'hD0000000, 32'h78010000, 32'h38210000,
		32'h78020000, 32'h38420000, 32'h58200000, 32'h58400004,
		32'h34210004, 32'h5C22FFFE, 32'h78030000, 32'h38630000,
		32'hC0600000, 32'h00000000, 32'h13004D31, 32'hDEADBEEF
	};

	logic              sys_clk = 1'b0;
	logic              trigger_reset;
	soc_pkg::wb_req_t  wb_req;
	soc_pkg::wb_rsp_t  wb_rsp;
	soc_pkg::btn_t     btn;
	soc_pkg::led_t     led;
	logic              flash_rst_n;
	logic              periph_rst_n;
	logic [31:0]       rng_state = 32'd60763;
	int                cycle_count = 0;
	int                errors = 0;
	int                checks = 0;
	int                tests_run = 0;
	int                tests_failed = 0;
	int                test_err_base = 0;
	soc_pkg::wb_data_t ram_model [RAM_WORDS];

	soc_top #(
		.RST_HOLD_CYCLES (RST_HOLD_CYCLES),
		.FLASH_RST_CYCLES(FLASH_RST_CYCLES),
		.ROM_ADDR_WIDTH  (ROM_ADDR_WIDTH),
		.RAM_ADDR_WIDTH  (RAM_ADDR_WIDTH)
	) i_dut (
		.sys_clk_i      (sys_clk),
		.trigger_reset_i(trigger_reset),
		.wb_req_i       (wb_req),
		.wb_rsp_o       (wb_rsp),
		.btn_i          (btn),
		.led_o          (led),
		.flash_rst_n_o  (flash_rst_n),
		.periph_rst_n_o (periph_rst_n)
	);

	// 10 ns clock
	always #5 sys_clk = ~sys_clk;

	// run limit
	always @(posedge sys_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles without reaching the end", cycle_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// --------------------
	// helpers
	// --------------------
	// lcg, upper half rotated down for better low bits
	function automatic logic [31:0] rand32();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return {rng_state[15:0], rng_state[31:16]};
	endfunction

	// csr slot, word address bits 15..2 carry peripheral and register
	function automatic soc_pkg::wb_adr_t csr_addr(input logic [3:0] per, input logic [9:0] idx);
		return 32'h6000_0000 | (32'(per) << 12) | (32'(idx) << 2);
	endfunction

	task automatic check_data(input string name, input soc_pkg::wb_data_t exp,
		input soc_pkg::wb_data_t act);
		checks++;
		if (act !== exp) begin
			$display("mismatch %s: expected %08h actual %08h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_led(input string name, input soc_pkg::led_t exp,
		input soc_pkg::led_t act);
		checks++;
		if (act !== exp) begin
			$display("mismatch %s: expected %02h actual %02h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			$display("mismatch %s: expected %b actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_cycles(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			$display("mismatch %s: expected %0d actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		int n;
		n = errors - test_err_base;
		tests_run++;
		if (n == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, n);
			tests_failed++;
		end
		test_err_base = errors;
	endtask

	// --------------------
	// bus master
	// --------------------
	// classic cycle: hold until ack, drop stb on the ack edge
	task automatic bus_access(input string name, input soc_pkg::wb_adr_t adr, input logic we,
		input soc_pkg::wb_sel_t sel, input soc_pkg::wb_data_t dat, input int exp_lat,
		output soc_pkg::wb_data_t rdata, output logic err, output logic acked);
		soc_pkg::wb_req_t req;
		int k;
		req = '0;
		req.adr = adr;
		req.dat_w = dat;
		req.sel = sel;
		req.we = we;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		rdata = '0;
		err = 1'b0;
		@(posedge sys_clk);
		wb_req <= req;
		k = 0;
		do begin
			@(posedge sys_clk);
			k++;
		end while (!wb_rsp.ack && k < 20);
		wb_req <= '0;
		acked = wb_rsp.ack;
		if (!acked) begin
			$display("%s: no ack within 20 cycles", name);
			errors++;
		end else begin
			rdata = wb_rsp.dat_r;
			err = wb_rsp.err;
			// edge k samples the ack cycle, stb started one edge earlier
			check_cycles({name, " latency"}, exp_lat, k - 1);
		end
	endtask

	task automatic read_expect(input string name, input soc_pkg::wb_adr_t adr, input int exp_lat,
		input soc_pkg::wb_data_t exp, input logic exp_err);
		soc_pkg::wb_data_t rdata;
		logic err;
		logic acked;
		bus_access(name, adr, 1'b0, 4'hF, '0, exp_lat, rdata, err, acked);
		if (acked) begin
			check_data(name, exp, rdata);
			check_flag({name, " err"}, exp_err, err);
		end
	endtask

	task automatic write_word(input string name, input soc_pkg::wb_adr_t adr,
		input soc_pkg::wb_sel_t sel, input soc_pkg::wb_data_t dat, input int exp_lat);
		soc_pkg::wb_data_t rdata;
		logic err;
		logic acked;
		bus_access(name, adr, 1'b1, sel, dat, exp_lat, rdata, err, acked);
		if (acked)
			check_flag({name, " err"}, 1'b0, err);
	endtask

	// whole ram against the model
	task automatic compare_ram(input string name);
		for (int i = 0; i < RAM_WORDS; i++)
			read_expect($sformatf("%s word %0d", name, i), 32'h4000_0000 + 32'(i) * 4, 1,
				ram_model[i], 1'b0);
	endtask

	// --------------------
	// reset observation
	// --------------------
	// called on the edge that drops the last reset source
	task automatic measure_release(input string name);
		int k;
		int flash_at;
		int periph_at;
		k = 0;
		flash_at = 0;
		periph_at = 0;
		while (periph_at == 0 && k < 200) begin
			@(posedge sys_clk);
			k++;
			if (flash_rst_n === 1'b1 && flash_at == 0)
				flash_at = k;
			if (periph_rst_n === 1'b1) begin
				periph_at = k;
			end else begin
				check_led({name, " led in reset"}, '0, led);
				check_flag({name, " ack in reset"}, 1'b0, wb_rsp.ack);
			end
		end
		if (periph_at == 0) begin
			$display("%s: peripheral reset never released", name);
			errors++;
		end else begin
			check_cycles({name, " flash release"}, FLASH_RST_CYCLES, flash_at);
			check_cycles({name, " periph release"}, RST_HOLD_CYCLES + 1, periph_at);
		end
	endtask

	// request still pending from before the reset, ack one cycle after release
	task automatic complete_held_read(input string name, input soc_pkg::wb_data_t exp);
		int k;
		k = 0;
		do begin
			@(posedge sys_clk);
			k++;
		end while (!wb_rsp.ack && k < 20);
		wb_req <= '0;
		if (!wb_rsp.ack) begin
			$display("%s: no ack after reset release", name);
			errors++;
		end else begin
			check_cycles({name, " latency"}, 1, k);
			check_data(name, exp, wb_rsp.dat_r);
		end
	endtask

	// source was driven on the previous edge
	task automatic expect_reset_fall(input string name);
		int k;
		k = 0;
		while (periph_rst_n && k < 10) begin
			@(posedge sys_clk);
			k++;
		end
		if (periph_rst_n) begin
			$display("%s: peripheral reset did not fall", name);
			errors++;
		end else if (k > 6) begin
			$display("%s: peripheral reset fell after %0d cycles, later than 6", name, k);
			errors++;
		end
	endtask

	task automatic wait_release(input string name);
		int k;
		k = 0;
		while (!periph_rst_n && k < 100) begin
			@(posedge sys_clk);
			k++;
		end
		if (!periph_rst_n) begin
			$display("%s: peripheral reset still held after %0d cycles", name, k);
			errors++;
		end
	endtask

	// write to hard reset, abandoned once the reset hits the bridge
	task automatic hard_reset_write();
		soc_pkg::wb_req_t req;
		req = '0;
		req.adr = csr_addr(soc_pkg::CSR_SYSCTL, soc_pkg::SYSCTL_HARD_RESET);
		req.dat_w = rand32();
		req.sel = 4'hF;
		req.we = 1'b1;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		@(posedge sys_clk);
		wb_req <= req;
		expect_reset_fall("hard reset write");
		wb_req <= '0;
	endtask

	task automatic hold_buttons();
		@(posedge sys_clk);
		btn <= 3'b111;
		expect_reset_fall("three buttons held");
		btn <= '0;
	endtask

	// after a reset request: registers cleared, ram kept
	task automatic check_after_reset(input string name);
		read_expect({name, " gpio_out"}, csr_addr(soc_pkg::CSR_SYSCTL, soc_pkg::SYSCTL_GPIO_OUT),
			3, '0, 1'b0);
		check_led({name, " led pins"}, '0, led);
		read_expect({name, " control"}, csr_addr(soc_pkg::CSR_SYSCTL, soc_pkg::SYSCTL_CONTROL),
			3, '0, 1'b0);
		compare_ram({name, " ram"});
	endtask

	// --------------------
	// test sequence
	// --------------------
	initial begin
		logic [31:0]       r;
		logic [31:0]       tmp;
		soc_pkg::wb_adr_t  adr;
		soc_pkg::wb_data_t dat;
		soc_pkg::wb_sel_t  sel;
		soc_pkg::btn_t     b;
		logic [3:0]        per;
		int                idx;
		soc_pkg::wb_req_t  held;

		trigger_reset = 1'b1;
		wb_req = '0;
		btn = '0;

		// 1: initial reset, then a short pulse
		repeat (8) @(posedge sys_clk);
		trigger_reset <= 1'b0;
		measure_release("initial reset");
		// leds lit so the pulse has something to clear
		write_word("led before pulse", csr_addr(soc_pkg::CSR_SYSCTL, soc_pkg::SYSCTL_GPIO_OUT),
			4'hF, 32'hC3, 3);
		check_led("led before pulse", 8'hC3, led);
		held = '0;
		held.adr = 32'h0004_0014;
		held.sel = 4'hF;
		held.cyc = 1'b1;
		held.stb = 1'b1;
		repeat (5) @(posedge sys_clk);
		trigger_reset <= 1'b1;
		@(posedge sys_clk);
		// rom read held through the pulse
		wb_req <= held;
		repeat (2) @(posedge sys_clk);
		trigger_reset <= 1'b0;
		measure_release("reset pulse");
		complete_held_read("read across reset", ROM_IMAGE[(32'h0004_0014 >> 2) % ROM_WORDS]);
		report_test("reset timing");

		// 2: fill, then random traffic with shadow and alias addresses
		for (int i = 0; i < RAM_WORDS; i++) begin
			dat = rand32();
			write_word("ram fill", 32'h4000_0000 + 32'(i) * 4, 4'hF, dat, 1);
			ram_model[i] = dat;
		end
		for (int i = 0; i < RAM_OPS; i++) begin
			r = rand32();
			tmp = rand32();
			adr = 32'h4000_0000 | (tmp & 32'h1FFF_FFFC);
			if (r[0])
				adr[31] = 1'b1;
			idx = (adr >> 2) % RAM_WORDS;
			if (r[1]) begin
				dat = rand32();
				sel = r[7:4];
				write_word($sformatf("ram write %08h", adr), adr, sel, dat, 1);
				for (int lane = 0; lane < 4; lane++) begin
					if (sel[lane])
						ram_model[idx][lane*8 +: 8] = dat[lane*8 +: 8];
				end
			end else begin
				read_expect($sformatf("ram read %08h", adr), adr, 1, ram_model[idx], 1'b0);
			end
		end
		report_test("scratch ram");

		// 3: rom above the null region, modulo 16 words
		for (int i = 0; i < 40; i++) begin
			r = rand32();
			tmp = rand32();
			adr = (32'h0004_0000 + (tmp % 32'h0FFC_0000)) & 32'hFFFF_FFFC;
			if (r[0])
				adr[31] = 1'b1;
			read_expect($sformatf("rom read %08h", adr), adr, 1, ROM_IMAGE[(adr >> 2) % ROM_WORDS],
				1'b0);
		end
		// debug, usb and ethernet slots
		for (int i = 0; i < 12; i++) begin
			r = rand32();
			tmp = rand32();
			adr = {r[0], 3'(1 + i % 3), tmp[27:0]};
			read_expect($sformatf("unmapped read %08h", adr), adr, 1, '0, 1'b0);
		end
		report_test("rom and unmapped slots");

		// 4: system controller through the csr bridge
		adr = csr_addr(soc_pkg::CSR_SYSCTL, soc_pkg::SYSCTL_SYSTEM_ID);
		read_expect("system id", adr, 3, 32'h13004D31, 1'b0);
		read_expect("system id shadow", adr | 32'h8000_0000, 3, 32'h13004D31, 1'b0);
		adr = csr_addr(soc_pkg::CSR_SYSCTL, soc_pkg::SYSCTL_GPIO_OUT);
		for (int i = 0; i < 8; i++) begin
			r = rand32();
			write_word("led write", adr, 4'hF, r, 3);
			check_led("led pins", r[7:0], led);
			read_expect("led readback", adr, 3, {24'd0, r[7:0]}, 1'b0);
		end
		// never all three, that is a reset request
		adr = csr_addr(soc_pkg::CSR_SYSCTL, soc_pkg::SYSCTL_GPIO_IN);
		for (int i = 0; i < 8; i++) begin
			r = rand32();
			b = soc_pkg::btn_t'(r % 7);
			btn <= b;
			repeat (3) @(posedge sys_clk);
			read_expect($sformatf("buttons %03b", b), adr, 3, {29'd0, b}, 1'b0);
		end
		btn <= '0;
		for (int i = 0; i < 8; i++) begin
			r = rand32();
			per = r[3:0];
			if (per == soc_pkg::CSR_SYSCTL)
				per = 4'hE;
			read_expect($sformatf("unknown peripheral %0d", per), csr_addr(per, r[13:4]), 3,
				'0, 1'b0);
		end
		// unused sysctl registers read zero too
		r = rand32();
		read_expect("unused sysctl register", csr_addr(soc_pkg::CSR_SYSCTL, 10'(5 + r % 1019)),
			3, '0, 1'b0);
		report_test("system controller");

		// 5: null-pointer error flag
		adr = csr_addr(soc_pkg::CSR_SYSCTL, soc_pkg::SYSCTL_CONTROL);
		write_word("control clear", adr, 4'hF, 32'h0, 3);
		read_expect("null read errors off", 32'h100, 1, ROM_IMAGE[(32'h100 >> 2) % ROM_WORDS],
			1'b0);
		write_word("control set", adr, 4'hF, 32'h1, 3);
		read_expect("control readback", adr, 3, 32'h1, 1'b0);
		read_expect("null read errors on", 32'h100, 1, ROM_IMAGE[(32'h100 >> 2) % ROM_WORDS],
			1'b1);
		read_expect("read above null region", 32'h4_0100, 1,
			ROM_IMAGE[(32'h4_0100 >> 2) % ROM_WORDS], 1'b0);
		report_test("bus error");

		// 6: software and button reset requests
		write_word("led set", csr_addr(soc_pkg::CSR_SYSCTL, soc_pkg::SYSCTL_GPIO_OUT), 4'hF,
			32'h5A, 3);
		check_led("led before hard reset", 8'h5A, led);
		hard_reset_write();
		wait_release("hard reset");
		check_after_reset("after hard reset");
		write_word("led set", csr_addr(soc_pkg::CSR_SYSCTL, soc_pkg::SYSCTL_GPIO_OUT), 4'hF,
			32'hA5, 3);
		write_word("control set", csr_addr(soc_pkg::CSR_SYSCTL, soc_pkg::SYSCTL_CONTROL), 4'hF,
			32'h1, 3);
		hold_buttons();
		wait_release("button reset");
		check_after_reset("after button reset");
		report_test("reset requests");

		$display("tests %0d, failing tests %0d, checks %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, checks, errors, i_dut.u_protocol_assert.fail_count);
		if (errors == 0 && i_dut.u_protocol_assert.fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: tb_soc_assert.sv
// bus protocol checker for the soc master port, bound into the top level
`timescale 1ns/100ps

module tb_soc_assert (
	input logic             sys_clk_i,
	input logic             sys_rst_i,
	input soc_pkg::wb_req_t wb_req_i,
	input soc_pkg::wb_rsp_t wb_rsp_i
);

	// failing assertion count
	int fail_count = 0;

	// --------------------
	// handshake
	// --------------------
	// ack only inside a live request
	ack_in_cycle: assert property (@(posedge sys_clk_i)
		wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb))
		else begin
			$error("ack seen without cyc and stb");
			fail_count++;
		end

	// err rides on ack
	err_with_ack: assert property (@(posedge sys_clk_i)
		wb_rsp_i.err |-> wb_rsp_i.ack)
		else begin
			$error("err seen without ack");
			fail_count++;
		end

	// one ack per request, never back to back
	single_ack: assert property (@(posedge sys_clk_i)
		wb_rsp_i.ack |=> !wb_rsp_i.ack)
		else begin
			$error("ack high in two consecutive cycles");
			fail_count++;
		end

	// bus quiet while in system reset
	quiet_in_reset: assert property (@(posedge sys_clk_i)
		sys_rst_i |-> !wb_rsp_i.ack)
		else begin
			$error("ack seen while system reset is high");
			fail_count++;
		end

endmodule

bind soc_top tb_soc_assert u_protocol_assert (
	.sys_clk_i(sys_clk_i),
	.sys_rst_i(sys_rst),
	.wb_req_i (wb_req_i),
	.wb_rsp_i (wb_rsp_o)
);

// File: wb_decoder.sv
// bus decoder: routes the master to rom, ram or csr and answers unmapped slots
`timescale 1ns/100ps

module wb_decoder (
	input  logic             sys_clk_i,
	input  logic             sys_rst_i,
	input  soc_pkg::wb_req_t wb_req_i,
	input  logic             bus_errors_en_i,
	output soc_pkg::wb_rsp_t wb_rsp_o,
	output soc_pkg::wb_req_t rom_req_o,
	input  soc_pkg::wb_rsp_t rom_rsp_i,
	output soc_pkg::wb_req_t ram_req_o,
	input  soc_pkg::wb_rsp_t ram_rsp_i,
	output soc_pkg::wb_req_t csr_req_o,
	input  soc_pkg::wb_rsp_t csr_rsp_i
);

	soc_pkg::slot_t   slot;
	soc_pkg::wb_rsp_t sel_rsp;
	logic             none_ack_q;
	logic             locked;

	// --------------------
	// slot decode
	// --------------------
	// bit 31 ignored, upper half shadows lower half
	always_comb begin
		if (wb_req_i.adr[30:28] == soc_pkg::SLOT_ROM_SEL)
			slot = soc_pkg::SLOT_ROM;
		else if (wb_req_i.adr[30:29] == soc_pkg::SLOT_RAM_SEL)
			slot = soc_pkg::SLOT_RAM;
		else if (wb_req_i.adr[30:29] == soc_pkg::SLOT_CSR_SEL)
			slot = soc_pkg::SLOT_CSR;
		else
			// debug, usb, ethernet
			slot = soc_pkg::SLOT_NONE;
	end

	// shared request, stb only to the selected slave
	always_comb begin
		rom_req_o     = wb_req_i;
		ram_req_o     = wb_req_i;
		csr_req_o     = wb_req_i;
		rom_req_o.stb = wb_req_i.stb & (slot == soc_pkg::SLOT_ROM);
		ram_req_o.stb = wb_req_i.stb & (slot == soc_pkg::SLOT_RAM);
		csr_req_o.stb = wb_req_i.stb & (slot == soc_pkg::SLOT_CSR);
	end

	// --------------------
	// default responder
	// --------------------
	// zero data, one cycle ack, never twice in a row
	always_ff @(posedge sys_clk_i) begin
		if (sys_rst_i)
			none_ack_q <= 1'b0;
		else
			none_ack_q <= wb_req_i.cyc & wb_req_i.stb & ~none_ack_q
				& (slot == soc_pkg::SLOT_NONE);
	end

	// response mux, address is held until ack
	always_comb begin
		case (slot)
			soc_pkg::SLOT_ROM: sel_rsp = rom_rsp_i;
			soc_pkg::SLOT_RAM: sel_rsp = ram_rsp_i;
			soc_pkg::SLOT_CSR: sel_rsp = csr_rsp_i;
			default: begin
				sel_rsp     = '0;
				sel_rsp.ack = none_ack_q;
			end
		endcase
	end

	// --------------------
	// null-pointer error
	// --------------------
	// lowest 256 KB, full address incl. bit 31
	assign locked = (wb_req_i.adr[31:soc_pkg::LOCKED_MSB] == '0);

	// err rides on ack, read data still passed
	always_comb begin
		wb_rsp_o     = sel_rsp;
		wb_rsp_o.err = sel_rsp.err | (sel_rsp.ack & bus_errors_en_i & locked);
	end

endmodule
